/* run.sh */
#!/bin/bash
# build and run the expander testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module rvc_expander_tb -o sim_rvc

# keep running past individual assertion errors so the summary is printed
./obj_dir/sim_rvc +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
grep -q "Test passed" sim.log

/* rvc_config.svh */
/* shared widths and fixed register numbers for the RV32C expander
   register constants are sized to the 5-bit register address */

`ifndef RVC_CONFIG_SVH
`define RVC_CONFIG_SVH

// full and compressed instruction widths
`define RVC_INSTR_W 32
`define RVC_CINSTR_W 16

// register address widths
`define RVC_REG_W 5
`define RVC_CREG_W 3

// fixed architectural registers
`define RVC_SP_REG 5'd2
`define RVC_RA_REG 5'd1

// upper bits that map x8..x15 for the 3-bit register fields
`define RVC_CREG_PREFIX 2'b01

// ebreak in the 32-bit encoding
`define RVC_EBREAK_WORD 32'h0010_0073

`endif

/* rvc_expander.sv */
/* RV32C expander with one registered stage, latency exactly one cycle
   no back-pressure, every valid output must be taken by the consumer
   data registers hold their value between valid inputs */

`timescale 1ns/1ps

`include "rvc_config.svh"

module rvc_expander (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            instr_valid_i,
  input  rvc_pkg::instr_t instr_i,
  output logic            instr_valid_o,
  output rvc_pkg::instr_t instr_o,
  output logic            is_compressed_o,
  output logic            illegal_instr_o
);

  // low halfword feeds all three quadrant decoders
  rvc_pkg::cinstr_t cinstr;

  // per-quadrant results
  rvc_pkg::instr_t  q0_instr;
  rvc_pkg::instr_t  q1_instr;
  rvc_pkg::instr_t  q2_instr;
  logic             q0_illegal;
  logic             q1_illegal;
  logic             q2_illegal;

  // selected result ahead of the output stage
  rvc_pkg::instr_t  exp_instr;
  logic             exp_compressed;
  logic             exp_illegal;

  assign cinstr = instr_i[`RVC_CINSTR_W-1:0];

  ////////////////////////////////////////
  // quadrant decoders
  ////////////////////////////////////////

  rvc_quadrant0_decoder u_q0 (
    .cinstr_i        (cinstr),
    .instr_o         (q0_instr),
    .illegal_instr_o (q0_illegal)
  );

  rvc_quadrant1_decoder u_q1 (
    .cinstr_i        (cinstr),
    .instr_o         (q1_instr),
    .illegal_instr_o (q1_illegal)
  );

  rvc_quadrant2_decoder u_q2 (
    .cinstr_i        (cinstr),
    .instr_o         (q2_instr),
    .illegal_instr_o (q2_illegal)
  );

  // quadrant select, 11 means a full 32-bit word passes through
  always_comb begin
    exp_compressed = (instr_i[1:0] != 2'b11);
    unique case (instr_i[1:0])
      2'b00: begin
        exp_instr   = q0_instr;
        exp_illegal = q0_illegal;
      end
      2'b01: begin
        exp_instr   = q1_instr;
        exp_illegal = q1_illegal;
      end
      2'b10: begin
        exp_instr   = q2_instr;
        exp_illegal = q2_illegal;
      end
      default: begin
        exp_instr   = instr_i;
        exp_illegal = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////
  // output stage
  ////////////////////////////////////////

  // strobe follows the input one cycle later, back-to-back included
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instr_valid_o <= 1'b0;
    end else begin
      instr_valid_o <= instr_valid_i;
    end
  end

  // results load only with a valid input
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instr_o         <= '0;
      is_compressed_o <= 1'b0;
      illegal_instr_o <= 1'b0;
    end else if (instr_valid_i) begin
      instr_o         <= exp_instr;
      is_compressed_o <= exp_compressed;
      illegal_instr_o <= exp_illegal;
    end
  end

endmodule

/* rvc_expander_assert.sv */
/* checker bound into rvc_expander, compares outputs with a one-cycle input history
   fail_count holds the number of failed checks since time zero */

`timescale 1ns/1ps

`include "rvc_config.svh"

module rvc_expander_assert (
  input logic            clk,
  input logic            rst_n_i,
  input logic            instr_valid_i,
  input rvc_pkg::instr_t instr_i,
  input logic            instr_valid_o,
  input rvc_pkg::instr_t instr_o,
  input logic            is_compressed_o,
  input logic            illegal_instr_o
);

  int               fail_count = 0;
  // inputs seen at the previous edge
  logic             prev_valid;
  rvc_pkg::instr_t  prev_instr;
  logic [15:0]      c;
  logic [2:0]       f3;
  // register forms and the fields they should produce
  logic             is_lw;
  logic             is_sw;
  logic             is_and;
  logic [4:0]       reg_a;
  logic [4:0]       reg_b;
  logic             map_ok;
  // fixed expansions
  logic             fixed_hit;
  rvc_pkg::instr_t  fixed_exp;
  logic             known_op;
  logic             bad_slot;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prev_valid <= 1'b0;
      prev_instr <= '0;
    end else begin
      prev_valid <= instr_valid_i;
      prev_instr <= instr_i;
    end
  end

  assign c  = prev_instr[15:0];
  assign f3 = c[15:13];

  ////////////////////////////////////////
  // expected values
  ////////////////////////////////////////

  // 3-bit fields name x8..x15
  assign reg_a  = 5'd8 + {2'b00, c[9:7]};
  assign reg_b  = 5'd8 + {2'b00, c[4:2]};
  assign is_lw  = (c[1:0] == 2'b00) && (f3 == 3'b010);
  assign is_sw  = (c[1:0] == 2'b00) && (f3 == 3'b110);
  assign is_and = (c[1:0] == 2'b01) && (c[15:10] == 6'b100011) && (c[6:5] == 2'b11);
  // rs1 always from [9:7], the [4:2] field lands in rd for lw and in rs2 otherwise
  assign map_ok = (instr_o[19:15] == reg_a)
                  && (is_lw ? (instr_o[11:7] == reg_b) : (instr_o[24:20] == reg_b))
                  && (!is_and || (instr_o[11:7] == reg_a));

  always_comb begin
    fixed_hit = 1'b0;
    fixed_exp = '0;
    if (c == 16'h9002) begin
      fixed_hit = 1'b1;
      fixed_exp = `RVC_EBREAK_WORD;
    end else if ((c[1:0] == 2'b10) && (c[15:13] == 3'b100) && (c[6:2] == 5'd0)
                 && (c[11:7] != 5'd0)) begin
      // c.jr links nothing, c.jalr links ra
      fixed_hit = 1'b1;
      fixed_exp = {12'b0, c[11:7], 3'b000, (c[12] ? `RVC_RA_REG : 5'd0),
                   rvc_pkg::OPCODE_JALR};
    end
  end

  assign known_op = instr_o[6:0] inside {rvc_pkg::OPCODE_OPIMM, rvc_pkg::OPCODE_OP,
                    rvc_pkg::OPCODE_LOAD, rvc_pkg::OPCODE_STORE, rvc_pkg::OPCODE_LUI,
                    rvc_pkg::OPCODE_JAL, rvc_pkg::OPCODE_JALR, rvc_pkg::OPCODE_BRANCH};

  // reserved, float and Zc slots per quadrant
  always_comb begin
    case (c[1:0])
      2'b00: bad_slot = (f3 inside {3'd1, 3'd3, 3'd4, 3'd5, 3'd7})
                        || ((f3 == 3'd0) && (c[12:5] == 8'd0));
      2'b01: bad_slot = ((f3 == 3'd4) && c[12] && (c[11:10] != 2'b10))
                        || ((f3 == 3'd3) && ({c[12], c[6:2]} == 6'd0));
      2'b10: bad_slot = (f3 inside {3'd1, 3'd3, 3'd5, 3'd7})
                        || ((f3 == 3'd0) && c[12])
                        || ((f3 == 3'd2) && (c[11:7] == 5'd0));
      default: bad_slot = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // strobe follows the input by one cycle, low through reset
  latency_chk: assert property (@(posedge clk) instr_valid_o == prev_valid)
    else begin
      $error("MISMATCH instr_valid_o %h expected %h", instr_valid_o, prev_valid);
      fail_count++;
    end

  pass_chk: assert property (@(posedge clk) disable iff (!rst_n_i)
    (prev_valid && (c[1:0] == 2'b11)) |->
    ((instr_o == prev_instr) && !is_compressed_o && !illegal_instr_o))
    else begin
      $error("MISMATCH instr_o %h expected %h, is_compressed_o %h illegal_instr_o %h",
             instr_o, prev_instr, is_compressed_o, illegal_instr_o);
      fail_count++;
    end

  compressed_chk: assert property (@(posedge clk) disable iff (!rst_n_i)
    (prev_valid && (c[1:0] != 2'b11)) |-> is_compressed_o)
    else begin
      $error("MISMATCH is_compressed_o %h expected 1 for %h", is_compressed_o, prev_instr);
      fail_count++;
    end

  // ebreak is the one legal result outside the eight opcodes
  shape_chk: assert property (@(posedge clk) disable iff (!rst_n_i)
    (instr_valid_o && is_compressed_o && !illegal_instr_o
     && (instr_o != `RVC_EBREAK_WORD)) |-> ((instr_o[1:0] == 2'b11) && known_op))
    else begin
      $error("MISMATCH instr_o %h is not a legal RV32I shape", instr_o);
      fail_count++;
    end

  regmap_chk: assert property (@(posedge clk) disable iff (!rst_n_i)
    (prev_valid && (is_lw || is_sw || is_and)) |-> map_ok)
    else begin
      $error("MISMATCH instr_o %h register fields for halfword %h", instr_o, c);
      fail_count++;
    end

  fixed_chk: assert property (@(posedge clk) disable iff (!rst_n_i)
    (prev_valid && fixed_hit) |-> ((instr_o == fixed_exp) && !illegal_instr_o))
    else begin
      $error("MISMATCH instr_o %h expected %h for halfword %h", instr_o, fixed_exp, c);
      fail_count++;
    end

  illegal_chk: assert property (@(posedge clk) disable iff (!rst_n_i)
    (prev_valid && bad_slot) |-> illegal_instr_o)
    else begin
      $error("MISMATCH illegal_instr_o %h expected 1 for halfword %h", illegal_instr_o, c);
      fail_count++;
    end

endmodule

/* rvc_expander_tb.sv */
/* testbench top for rvc_expander, checking lives in the bound checker
   stimulus is random with a fixed seed, directed fields where needed */

`timescale 1ns/1ps

module rvc_expander_tb;

  localparam logic [31:0] SEED = 32'h349154f1;
  localparam int LAT_N = 16;
  localparam int PASS_N = 64;
  localparam int MAP_N = 16;
  localparam int FIX_N = 8;
  localparam int ILL_N = 4;
  localparam int DRAIN = 3;
  // one cycle per word plus the drain of each test
  localparam int TEST_CYCLES = (LAT_N + DRAIN) + (PASS_N + DRAIN) + (3 * MAP_N + DRAIN)
                               + (2 + 2 * FIX_N + DRAIN) + (13 * ILL_N + DRAIN);
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 5;
  // reserved funct3 values in C0 and C2
  localparam logic [2:0] C0_BAD [5] = '{3'd1, 3'd3, 3'd4, 3'd5, 3'd7};
  localparam logic [2:0] C2_BAD [4] = '{3'd1, 3'd3, 3'd5, 3'd7};

  logic            clk;
  logic            rst_n_i;
  logic            instr_valid_i;
  rvc_pkg::instr_t instr_i;
  logic            instr_valid_o;
  rvc_pkg::instr_t instr_o;
  logic            is_compressed_o;
  logic            illegal_instr_o;
  int              cycles = 0;
  int              tests_run = 0;
  int              tests_bad = 0;
  int              fails_seen = 0;

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n_i)
  );

  rvc_expander uut (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .instr_valid_i   (instr_valid_i),
    .instr_i         (instr_i),
    .instr_valid_o   (instr_valid_o),
    .instr_o         (instr_o),
    .is_compressed_o (is_compressed_o),
    .illegal_instr_o (illegal_instr_o)
  );

  bind rvc_expander rvc_expander_assert u_chk (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .instr_valid_i   (instr_valid_i),
    .instr_i         (instr_i),
    .instr_valid_o   (instr_valid_o),
    .instr_o         (instr_o),
    .is_compressed_o (is_compressed_o),
    .illegal_instr_o (illegal_instr_o)
  );

  ////////////////////////////////////////
  // drive helpers
  ////////////////////////////////////////

  task automatic send(input rvc_pkg::instr_t word);
    @(posedge clk);
    instr_valid_i <= 1'b1;
    instr_i       <= word;
  endtask

  task automatic idle();
    @(posedge clk);
    instr_valid_i <= 1'b0;
  endtask

  // let the last word reach the checker, then report the test
  task automatic finish_test(input string name);
    int now_fails;
    idle();
    repeat (DRAIN - 1) @(posedge clk);
    // counts from the last sampling edge are settled by the falling edge
    @(negedge clk);
    now_fails = uut.u_chk.fail_count;
    tests_run++;
    if (now_fails != fails_seen) begin
      tests_bad++;
    end
    $display("test %-12s %s, %0d assertion errors", name,
             (now_fails == fails_seen) ? "ok" : "FAIL", now_fails - fails_seen);
    fails_seen = now_fails;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  // random strobes give gaps and back-to-back words in any quadrant
  task automatic run_latency();
    logic [31:0] r;
    for (int i = 0; i < LAT_N; i++) begin
      r = $urandom;
      if (r[31]) begin
        send(r);
      end else begin
        idle();
      end
    end
    finish_test("latency");
  endtask

  task automatic run_passthru();
    logic [31:0] r;
    for (int i = 0; i < PASS_N; i++) begin
      r = $urandom;
      send({r[31:2], 2'b11});
    end
    finish_test("passthru");
  endtask

  // c.lw, c.sw and c.and with random register fields
  task automatic run_regmap();
    logic [31:0] r;
    for (int i = 0; i < MAP_N; i++) begin
      r = $urandom;
      send({r[31:16], 3'b010, r[12:2], 2'b00});
      send({r[31:16], 3'b110, r[12:2], 2'b00});
      send({r[31:16], 6'b100011, r[9:7], 2'b11, r[4:2], 2'b01});
    end
    finish_test("regmap");
  endtask

  // ebreak, the zero halfword, then c.jr / c.jalr pairs
  task automatic run_fixed();
    logic [31:0] r;
    logic [4:0]  rs;
    r = $urandom;
    send({r[31:16], 16'h9002});
    send({r[31:16], 16'h0000});
    for (int i = 0; i < FIX_N; i++) begin
      r  = $urandom;
      rs = (r[11:7] == 5'd0) ? 5'd1 : r[11:7];
      send({r[31:16], 4'b1000, rs, 5'd0, 2'b10});
      send({r[31:16], 4'b1001, rs, 5'd0, 2'b10});
    end
    finish_test("fixed");
  endtask

  task automatic run_illegal();
    logic [31:0] r;
    for (int k = 0; k < ILL_N; k++) begin
      for (int i = 0; i < 5; i++) begin
        r = $urandom;
        send({r[31:16], C0_BAD[i], r[12:2], 2'b00});
      end
      for (int i = 0; i < 4; i++) begin
        r = $urandom;
        send({r[31:16], C2_BAD[i], r[12:2], 2'b10});
      end
      // subw/addw and the 11x group
      r = $urandom;
      send({r[31:16], 4'b1001, 2'b11, r[9:2], 2'b01});
      // srli/srai with shamt[5]
      r = $urandom;
      send({r[31:16], 4'b1001, 1'b0, r[10:2], 2'b01});
      // slli with shamt[5]
      r = $urandom;
      send({r[31:16], 4'b0001, r[11:2], 2'b10});
      // c.lwsp into x0
      r = $urandom;
      send({r[31:16], 3'b010, r[12], 5'd0, r[6:2], 2'b10});
    end
    finish_test("illegal_set");
  endtask

  ////////////////////////////////////////
  // sequence and end of run
  ////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    instr_valid_i = 1'b0;
    instr_i       = '0;
    @(posedge rst_n_i);
    run_latency();
    run_passthru();
    run_regmap();
    run_fixed();
    run_illegal();
    $display("summary: %0d tests, %0d failing, %0d assertion errors",
             tests_run, tests_bad, uut.u_chk.fail_count);
    if ((tests_bad == 0) && (uut.u_chk.fail_count == 0)) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // hard stop if the sequence never completes
  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

endmodule

/* rvc_pkg.sv */
/* vector types and RV32I major opcodes shared by the expander modules
   widths come from rvc_config.svh */

`include "rvc_config.svh"

package rvc_pkg;

  ////////////////////////////////////////
  // vector types
  ////////////////////////////////////////

  // full 32-bit instruction word
  typedef logic [`RVC_INSTR_W-1:0] instr_t;

  // 16-bit compressed instruction
  typedef logic [`RVC_CINSTR_W-1:0] cinstr_t;

  // major opcode field, bits 6:0
  typedef logic [6:0] opcode_t;

  // x0..x31 register address
  typedef logic [`RVC_REG_W-1:0] reg_addr_t;

  // compressed register field, maps to x8..x15
  typedef logic [`RVC_CREG_W-1:0] creg_t;

  ////////////////////////////////////////
  // RV32I opcodes
  ////////////////////////////////////////

  // register-immediate ALU
  localparam opcode_t OPCODE_OPIMM = 7'h13;

  // register-register ALU
  localparam opcode_t OPCODE_OP = 7'h33;

  // loads and stores
  localparam opcode_t OPCODE_LOAD = 7'h03;
  localparam opcode_t OPCODE_STORE = 7'h23;

  // upper immediate
  localparam opcode_t OPCODE_LUI = 7'h37;

  // jumps
  localparam opcode_t OPCODE_JAL = 7'h6f;
  localparam opcode_t OPCODE_JALR = 7'h67;

  // conditional branches
  localparam opcode_t OPCODE_BRANCH = 7'h63;

endpackage

/* rvc_quadrant0_decoder.sv */
/* expands quadrant 0 halfwords, purely combinational
   only c.addi4spn, c.lw and c.sw are legal; float and Zc slots flag illegal
   instr_o is a don't-care whenever illegal_instr_o is set */

`timescale 1ns/1ps

`include "rvc_config.svh"

module rvc_quadrant0_decoder (
  input  rvc_pkg::cinstr_t cinstr_i,
  output rvc_pkg::instr_t  instr_o,
  output logic             illegal_instr_o
);

  // compressed register fields
  rvc_pkg::creg_t     rd_c;
  rvc_pkg::creg_t     rs1_c;
  // mapped onto x8..x15
  rvc_pkg::reg_addr_t rd_p;
  rvc_pkg::reg_addr_t rs1_p;
  // load form, also the filler for reserved slots
  rvc_pkg::instr_t    lw_instr;

  assign rd_c  = cinstr_i[4:2];
  assign rs1_c = cinstr_i[9:7];
  assign rd_p  = {`RVC_CREG_PREFIX, rd_c};
  assign rs1_p = {`RVC_CREG_PREFIX, rs1_c};

  // lw rd', uimm(rs1'), uimm = {c[5], c[12:10], c[6], 00}
  assign lw_instr = {5'b0, cinstr_i[5], cinstr_i[12:10], cinstr_i[6], 2'b00,
                     rs1_p, 3'b010, rd_p, rvc_pkg::OPCODE_LOAD};

  always_comb begin
    illegal_instr_o = 1'b0;
    instr_o         = lw_instr;

    unique case (cinstr_i[15:13])
      3'b000: begin
        // c.addi4spn -> addi rd', x2, nzuimm
        instr_o = {2'b0, cinstr_i[10:7], cinstr_i[12:11], cinstr_i[5], cinstr_i[6],
                   2'b00, `RVC_SP_REG, 3'b000, rd_p, rvc_pkg::OPCODE_OPIMM};
        // all-zero immediate is reserved, covers the all-zero halfword
        if (cinstr_i[12:5] == 8'b0) begin
          illegal_instr_o = 1'b1;
        end
      end

      3'b010: begin
        // c.lw, the default already holds the expansion
        instr_o = lw_instr;
      end

      3'b110: begin
        // c.sw -> sw rs2', uimm(rs1')
        instr_o = {5'b0, cinstr_i[5], cinstr_i[12], rd_p, rs1_p, 3'b010,
                   cinstr_i[11:10], cinstr_i[6], 2'b00, rvc_pkg::OPCODE_STORE};
      end

      default: begin
        // 001 c.fld / Zc loads, 011 c.flw, 100 Zc byte/half ops
        // 101 c.fsd / Zc stores, 111 c.fsw
        illegal_instr_o = 1'b1;
      end
    endcase
  end

endmodule

/* rvc_quadrant1_decoder.sv */
/* expands quadrant 1 halfwords, purely combinational
   hints expand like their base forms; subw/addw and the Zc group flag illegal
   instr_o is a don't-care whenever illegal_instr_o is set */

`timescale 1ns/1ps

`include "rvc_config.svh"

module rvc_quadrant1_decoder (
  input  rvc_pkg::cinstr_t cinstr_i,
  output rvc_pkg::instr_t  instr_o,
  output logic             illegal_instr_o
);

  // full register field at [11:7]
  rvc_pkg::reg_addr_t rd;
  // compressed fields, rs1'/rd' at [9:7], rs2' at [4:2]
  rvc_pkg::creg_t     rs1_c;
  rvc_pkg::creg_t     rs2_c;
  rvc_pkg::reg_addr_t rs1_p;
  rvc_pkg::reg_addr_t rs2_p;
  // c.jal links into ra, c.j into x0
  rvc_pkg::reg_addr_t jal_rd;
  // sign-extended 6-bit immediate, shared by addi/li/andi
  logic [11:0]        imm6;
  // register-register form with funct7/funct3 slots open
  rvc_pkg::instr_t    op_instr;

  assign rd     = cinstr_i[11:7];
  assign rs1_c  = cinstr_i[9:7];
  assign rs2_c  = cinstr_i[4:2];
  assign rs1_p  = {`RVC_CREG_PREFIX, rs1_c};
  assign rs2_p  = {`RVC_CREG_PREFIX, rs2_c};
  assign jal_rd = cinstr_i[15] ? 5'd0 : `RVC_RA_REG;
  assign imm6   = {{7{cinstr_i[12]}}, cinstr_i[6:2]};

  // and rd', rd', rs2' also fills the reserved arithmetic slots
  assign op_instr = {7'b0, rs2_p, rs1_p, 3'b111, rs1_p, rvc_pkg::OPCODE_OP};

  always_comb begin
    illegal_instr_o = 1'b0;
    instr_o         = op_instr;

    unique case (cinstr_i[15:13])
      3'b000: begin
        // c.addi -> addi rd, rd, imm, also c.nop
        instr_o = {imm6, rd, 3'b000, rd, rvc_pkg::OPCODE_OPIMM};
      end

      3'b001, 3'b101: begin
        // c.jal / c.j -> jal ra/x0, offset
        // jal layout is imm[20|10:1|11|19:12]
        instr_o = {cinstr_i[12], cinstr_i[8], cinstr_i[10:9], cinstr_i[6],
                   cinstr_i[7], cinstr_i[2], cinstr_i[11], cinstr_i[5:3],
                   {9{cinstr_i[12]}}, jal_rd, rvc_pkg::OPCODE_JAL};
      end

      3'b010: begin
        // c.li -> addi rd, x0, imm, rd zero is a hint
        instr_o = {imm6, 5'd0, 3'b000, rd, rvc_pkg::OPCODE_OPIMM};
      end

      3'b011: begin
        if (rd == `RVC_SP_REG) begin
          // c.addi16sp -> addi x2, x2, nzimm, imm scaled by 16
          instr_o = {{3{cinstr_i[12]}}, cinstr_i[4:3], cinstr_i[5], cinstr_i[2],
                     cinstr_i[6], 4'b0, `RVC_SP_REG, 3'b000, `RVC_SP_REG,
                     rvc_pkg::OPCODE_OPIMM};
        end else begin
          // c.lui -> lui rd, nzimm, rd zero is a hint
          instr_o = {{15{cinstr_i[12]}}, cinstr_i[6:2], rd, rvc_pkg::OPCODE_LUI};
        end
        // zero immediate reserved for both forms
        if ({cinstr_i[12], cinstr_i[6:2]} == 6'b0) begin
          illegal_instr_o = 1'b1;
        end
      end

      3'b100: begin
        unique case (cinstr_i[11:10])
          2'b00, 2'b01: begin
            // c.srli / c.srai -> srli/srai rd', rd', shamt
            // bit 10 picks the arithmetic shift via funct7[5]
            instr_o = {1'b0, cinstr_i[10], 5'b0, cinstr_i[6:2], rs1_p, 3'b101,
                       rs1_p, rvc_pkg::OPCODE_OPIMM};
            // shamt[5] set has no RV32 meaning
            if (cinstr_i[12]) begin
              illegal_instr_o = 1'b1;
            end
          end

          2'b10: begin
            // c.andi -> andi rd', rd', imm
            instr_o = {imm6, rs1_p, 3'b111, rs1_p, rvc_pkg::OPCODE_OPIMM};
          end

          default: begin
            unique case ({cinstr_i[12], cinstr_i[6:5]})
              // c.sub -> sub rd', rd', rs2'
              3'b000: instr_o = {7'b0100000, rs2_p, rs1_p, 3'b000, rs1_p,
                                 rvc_pkg::OPCODE_OP};
              // c.xor
              3'b001: instr_o = {7'b0, rs2_p, rs1_p, 3'b100, rs1_p, rvc_pkg::OPCODE_OP};
              // c.or
              3'b010: instr_o = {7'b0, rs2_p, rs1_p, 3'b110, rs1_p, rvc_pkg::OPCODE_OP};
              // c.and
              3'b011: instr_o = op_instr;
              default: begin
                // 100 c.subw, 101 c.addw, 11x c.mul and Zc unary ops
                illegal_instr_o = 1'b1;
              end
            endcase
          end
        endcase
      end

      default: begin
        // c.beqz / c.bnez -> beq/bne rs1', x0, offset
        // funct3 lsb comes straight from bit 13
        instr_o = {{4{cinstr_i[12]}}, cinstr_i[6:5], cinstr_i[2], 5'd0, rs1_p,
                   2'b00, cinstr_i[13], cinstr_i[11:10], cinstr_i[4:3],
                   cinstr_i[12], rvc_pkg::OPCODE_BRANCH};
      end
    endcase
  end

endmodule

/* rvc_quadrant2_decoder.sv */
/* expands quadrant 2 halfwords, purely combinational
   float and Zc slots flag illegal; instr_o is a don't-care when illegal */

`timescale 1ns/1ps

`include "rvc_config.svh"

module rvc_quadrant2_decoder (
  input  rvc_pkg::cinstr_t cinstr_i,
  output rvc_pkg::instr_t  instr_o,
  output logic             illegal_instr_o
);

  // rd / rs1 at [11:7], rs2 at [6:2], both full width here
  rvc_pkg::reg_addr_t rd;
  rvc_pkg::reg_addr_t rs2;
  // lwsp form, also the filler for reserved slots
  rvc_pkg::instr_t    lwsp_instr;

  assign rd  = cinstr_i[11:7];
  assign rs2 = cinstr_i[6:2];

  // lw rd, uimm(x2), uimm = {c[3:2], c[12], c[6:4], 00}
  assign lwsp_instr = {4'b0, cinstr_i[3:2], cinstr_i[12], cinstr_i[6:4], 2'b00,
                       `RVC_SP_REG, 3'b010, rd, rvc_pkg::OPCODE_LOAD};

  always_comb begin
    illegal_instr_o = 1'b0;
    instr_o         = lwsp_instr;

    unique case (cinstr_i[15:13])
      3'b000: begin
        // c.slli -> slli rd, rd, shamt, rd or shamt zero is a hint
        instr_o = {7'b0, rs2, rd, 3'b001, rd, rvc_pkg::OPCODE_OPIMM};
        // shamt[5] set has no RV32 meaning
        if (cinstr_i[12]) begin
          illegal_instr_o = 1'b1;
        end
      end

      3'b010: begin
        // c.lwsp, rd zero reserved
        instr_o = lwsp_instr;
        if (rd == 5'd0) begin
          illegal_instr_o = 1'b1;
        end
      end

      3'b100: begin
        if (rs2 == 5'd0) begin
          if (!cinstr_i[12]) begin
            // c.jr -> jalr x0, 0(rs1)
            instr_o = {12'b0, rd, 3'b000, 5'd0, rvc_pkg::OPCODE_JALR};
            // rs1 zero reserved
            if (rd == 5'd0) begin
              illegal_instr_o = 1'b1;
            end
          end else if (rd == 5'd0) begin
            // c.ebreak
            instr_o = `RVC_EBREAK_WORD;
          end else begin
            // c.jalr -> jalr ra, 0(rs1)
            instr_o = {12'b0, rd, 3'b000, `RVC_RA_REG, rvc_pkg::OPCODE_JALR};
          end
        end else begin
          // c.mv -> add rd, x0, rs2
          // c.add -> add rd, rd, rs2
          // bit 12 selects whether rd is also the first source
          // rd zero is a hint in both
          instr_o = {7'b0, rs2, (cinstr_i[12] ? rd : 5'd0), 3'b000, rd,
                     rvc_pkg::OPCODE_OP};
        end
      end

      3'b110: begin
        // c.swsp -> sw rs2, uimm(x2), uimm = {c[8:7], c[12:9], 00}
        instr_o = {4'b0, cinstr_i[8:7], cinstr_i[12], rs2, `RVC_SP_REG, 3'b010,
                   cinstr_i[11:9], 2'b00, rvc_pkg::OPCODE_STORE};
      end

      default: begin
        // 001 c.fldsp / Zc, 011 c.flwsp, 101 c.fsdsp, 111 c.fswsp
        illegal_instr_o = 1'b1;
      end
    endcase
  end

endmodule

/* sources.f */
+incdir+.
rvc_pkg.sv
rvc_quadrant0_decoder.sv
rvc_quadrant1_decoder.sv
rvc_quadrant2_decoder.sv
rvc_expander.sv
tb_clock_gen.sv
rvc_expander_assert.sv
rvc_expander_tb.sv

/* tb_clock_gen.sv */
/* testbench clock and reset, 10 ns period
   reset is held low for 5 rising edges and released on a falling edge */

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // free-running clock, 5 ns half period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule
